//--- source/bufferPkg.sv
// Buffer storage definitions
package bufferPkg;

	//****************************************
	// Widths and depths
	//****************************************

	// One sample of channel data per clock
	localparam int sampleWidth = 32;
	// Pipeline entries, sets the longest hold latency
	localparam int pipeDepth = 128;
	localparam int pipeAddrWidth = $clog2(pipeDepth);
	// L0 identifier doubles as event buffer address
	localparam int l0IdWidth = 8;
	localparam int eventDepth = 2 ** l0IdWidth;
	// Request queue entries per command line
	localparam int fifoDepth = 8;
	localparam int fifoPtrWidth = $clog2(fifoDepth);

	//****************************************
	// Types
	//****************************************

	typedef logic [sampleWidth-1:0] sampleT;
	typedef logic [pipeAddrWidth-1:0] pipeAddrT;
	typedef logic [l0IdWidth-1:0] l0IdT;
	// Identifier in the upper bits, sample below
	typedef logic [l0IdWidth+sampleWidth-1:0] eventT;
	typedef logic [fifoPtrWidth-1:0] fifoPtrT;
	// One bit wider than a pointer so full is reachable
	typedef logic [fifoPtrWidth:0] fifoCountT;

endpackage

//--- source/commandPkg.sv
// Serial command definitions
package commandPkg;

	//****************************************
	// Frame format
	//****************************************

	// Header leads the frame, MSB first
	localparam int headerBits = 3;
	typedef logic [headerBits-1:0] headerT;

	// Header codes of the two readout requests
	localparam headerT r3Header = 3'b101;
	localparam headerT l1Header = 3'b110;

	// Identifier bits after the header
	localparam int frameBits = 8;

	// Detector FSM states
	typedef enum logic [1:0] {
		idle,
		header,
		payload
	} detStateT;

endpackage

//--- source/bufferIfs.sv
// Event buffer and request queue interfaces
`timescale 1ns/1ps

//****************************************
// Event buffer port
//****************************************
interface eventPortIf;
	// Write side, one strobe per captured L0
	logic writeStrobe;
	bufferPkg::l0IdT writeAddr;
	bufferPkg::eventT writeData;
	// Read side, data valid the cycle after the strobe
	logic readStrobe;
	bufferPkg::l0IdT readAddr;
	bufferPkg::eventT readData;

	modport ctrl (
		output writeStrobe, writeAddr, writeData,
		output readStrobe, readAddr,
		input readData
	);

	modport mem (
		input writeStrobe, writeAddr, writeData,
		input readStrobe, readAddr,
		output readData
	);
endinterface

//****************************************
// Request queue
//****************************************
interface requestFifoIf;
	// Detected identifier from the serial line
	logic push;
	bufferPkg::l0IdT pushId;
	// Oldest queued identifier, taken on pop
	logic pop;
	bufferPkg::l0IdT headId;
	// Occupancy flags, levels
	logic empty;
	logic full;

	modport writer (output push, pushId);
	modport reader (output pop, input headId, empty);
	modport fifo (input push, pushId, pop, output headId, empty, full);
endinterface

//--- source/pipelineBuffer.sv
// Pipeline sample memory
`timescale 1ns/1ps

module pipelineBuffer (
	input logic CLK,
	input logic rstN,
	input logic l0a,
	input bufferPkg::pipeAddrT holdAddress,
	input bufferPkg::sampleT data,
	output bufferPkg::sampleT heldSample
);

	// Circular store, one entry per clock
	bufferPkg::sampleT samples [bufferPkg::pipeDepth];
	bufferPkg::pipeAddrT writePtr;

	// Free-running write pointer, wraps at pipeDepth
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			writePtr <= '0;
		end else begin
			writePtr <= writePtr + 1'b1;
		end
	end

	// Every sample is stored, nothing is held back
	always_ff @(posedge CLK) begin
		samples[writePtr] <= data;
	end

	// Entry holdAddress behind the pointer, modulo depth
	// Zero latency would hit the entry being written now
	always_ff @(posedge CLK) begin
		if (l0a) begin
			heldSample <= samples[writePtr - holdAddress];
		end
	end

	holdNotZero: assert property (@(posedge CLK) disable iff (!rstN)
		l0a |-> holdAddress != '0)
		else $error("L0 accept with zero hold latency");

endmodule

//--- source/commandDetector.sv
// Serial readout command detector
`timescale 1ns/1ps

module commandDetector #(
	parameter commandPkg::headerT header = commandPkg::r3Header
) (
	input logic CLK,
	input logic rstN,
	input logic serialIn,
	requestFifoIf.writer fifo
);

	localparam int countWidth = $clog2(commandPkg::frameBits);
	// Bit counter values of the last header and last identifier bits
	localparam logic [countWidth-1:0] lastHeaderBit = countWidth'(commandPkg::headerBits - 1);
	localparam logic [countWidth-1:0] lastIdBit = countWidth'(commandPkg::frameBits - 1);

	commandPkg::detStateT state;
	logic [countWidth-1:0] bitCount;
	// Header bits seen so far, the newest bit comes straight from the line
	logic [commandPkg::headerBits-2:0] headShift;
	bufferPkg::l0IdT idShift;

	//****************************************
	// Frame FSM
	//****************************************
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= commandPkg::idle;
			bitCount <= '0;
			fifo.push <= 1'b0;
		end else begin
			fifo.push <= 1'b0;
			case (state)
				// Line idles low, a high bit opens a frame
				commandPkg::idle: begin
					if (serialIn) begin
						state <= commandPkg::header;
						bitCount <= countWidth'(1);
					end
				end
				commandPkg::header: begin
					bitCount <= bitCount + 1'b1;
					if (bitCount == lastHeaderBit) begin
						bitCount <= '0;
						// Foreign or corrupt header, back to idle
						if ({headShift, serialIn} == header) begin
							state <= commandPkg::payload;
						end else begin
							state <= commandPkg::idle;
						end
					end
				end
				commandPkg::payload: begin
					bitCount <= bitCount + 1'b1;
					if (bitCount == lastIdBit) begin
						state <= commandPkg::idle;
						fifo.push <= 1'b1;
					end
				end
				default: state <= commandPkg::idle;
			endcase
		end
	end

	// Shift registers, MSB first
	always_ff @(posedge CLK) begin
		headShift <= {headShift[commandPkg::headerBits-3:0], serialIn};
		if (state == commandPkg::payload) begin
			idShift <= {idShift[commandPkg::frameBits-2:0], serialIn};
		end
	end

	// Identifier is complete while push is high
	assign fifo.pushId = idShift;

endmodule

//--- source/readoutFifo.sv
// Request identifier queue
`timescale 1ns/1ps

module readoutFifo (
	input logic CLK,
	input logic rstN,
	requestFifoIf.fifo port
);

	bufferPkg::l0IdT entries [bufferPkg::fifoDepth];
	bufferPkg::fifoPtrT writePtr;
	bufferPkg::fifoPtrT readPtr;
	bufferPkg::fifoCountT count;
	logic doPush;
	logic doPop;

	// Push into a full queue is lost, pop on empty is ignored
	assign doPush = port.push && !port.full;
	assign doPop = port.pop && !port.empty;

	//****************************************
	// Pointers and occupancy
	//****************************************
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) writePtr <= writePtr + 1'b1;
			if (doPop) readPtr <= readPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush) entries[writePtr] <= port.pushId;
	end

	// Show-ahead, the head is visible before the pop
	assign port.headId = entries[readPtr];
	assign port.empty = (count == '0);
	assign port.full = (count == bufferPkg::fifoDepth);

	// Readout side must look at empty before popping
	noPopEmpty: assert property (@(posedge CLK) disable iff (!rstN)
		port.pop |-> !port.empty)
		else $error("pop on empty request queue");
	countBound: assert property (@(posedge CLK) disable iff (!rstN)
		count <= bufferPkg::fifoDepth)
		else $error("request queue count overflow");

endmodule

//--- source/eventBuffer.sv
// Event memory indexed by L0 identifier
`timescale 1ns/1ps

module eventBuffer (
	input logic CLK,
	eventPortIf.mem port
);

	// One word per identifier value
	bufferPkg::eventT events [bufferPkg::eventDepth];

	// Write port, fed one cycle after each L0 accept
	always_ff @(posedge CLK) begin
		if (port.writeStrobe) begin
			events[port.writeAddr] <= port.writeData;
		end
	end

	// Registered read, data holds until the next read
	always_ff @(posedge CLK) begin
		if (port.readStrobe) begin
			port.readData <= events[port.readAddr];
		end
	end

	// Readout of an event still being captured
	noCollision: assert property (@(posedge CLK)
		!(port.writeStrobe && port.readStrobe && port.writeAddr == port.readAddr))
		else $error("event read and write to the same address");

endmodule

//--- source/readoutControl.sv
// L0 identifier and readout control
`timescale 1ns/1ps

module readoutControl (
	input logic CLK,
	input logic rstN,
	input logic l0a,
	input logic l0IdReset,
	input logic l0IdPreset,
	input bufferPkg::l0IdT preL0Id,
	input bufferPkg::sampleT heldSample,
	input logic r3ReadEnable,
	input logic l1ReadEnable,
	requestFifoIf.reader r3Fifo,
	requestFifoIf.reader l1Fifo,
	eventPortIf.ctrl mem,
	output logic l1bReadR3,
	output logic l1bReadL1,
	output bufferPkg::eventT l1bDataOut,
	output bufferPkg::l0IdT l0IdLocal
);

	bufferPkg::l0IdT captureId;
	logic pendingL1;
	logic serveR3;
	logic serveL1;

	//****************************************
	// L0 identifier and event capture
	//****************************************
	// Reset beats preset, both beat the increment
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			l0IdLocal <= '0;
			mem.writeStrobe <= 1'b0;
		end else begin
			if (l0IdReset) l0IdLocal <= '0;
			else if (l0IdPreset) l0IdLocal <= preL0Id;
			else if (l0a) l0IdLocal <= l0IdLocal + 1'b1;
			// Held sample arrives one cycle after l0a
			mem.writeStrobe <= l0a;
		end
	end

	// Identifier before the increment
	always_ff @(posedge CLK) begin
		captureId <= l0IdLocal;
	end

	assign mem.writeAddr = captureId;
	assign mem.writeData = {captureId, heldSample};

	//****************************************
	// Read arbitration
	//****************************************
	// R3 wins, a blocked L1 waits in pendingL1
	assign serveR3 = r3ReadEnable && !r3Fifo.empty;
	assign serveL1 = (l1ReadEnable || pendingL1) && !serveR3 && !l1Fifo.empty;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pendingL1 <= 1'b0;
			l1bReadR3 <= 1'b0;
			l1bReadL1 <= 1'b0;
		end else begin
			pendingL1 <= (l1ReadEnable || pendingL1) && serveR3 && !l1Fifo.empty;
			// Strobes line up with the registered read data
			l1bReadR3 <= serveR3;
			l1bReadL1 <= serveL1;
		end
	end

	assign r3Fifo.pop = serveR3;
	assign l1Fifo.pop = serveL1;
	assign mem.readStrobe = serveR3 || serveL1;
	assign mem.readAddr = serveR3 ? r3Fifo.headId : l1Fifo.headId;
	assign l1bDataOut = mem.readData;

	oneSource: assert property (@(posedge CLK) disable iff (!rstN)
		!(l1bReadR3 && l1bReadL1))
		else $error("R3 and L1 read strobes together");

endmodule

//--- source/l0l1Buffer.sv
// L0 and L1 trigger buffer
`timescale 1ns/1ps

module l0l1Buffer (
	input logic CLK,
	input logic rstN,
	input logic l0a,
	input logic l0IdReset,
	input logic l0IdPreset,
	input bufferPkg::l0IdT preL0Id,
	input bufferPkg::pipeAddrT pipeHoldAddress,
	input bufferPkg::sampleT data,
	input logic r3DataIn,
	input logic l1DataIn,
	input logic r3ReadEnable,
	input logic l1ReadEnable,
	output logic l1bReadR3,
	output logic l1bReadL1,
	output bufferPkg::eventT l1bDataOut,
	output logic r3Empty,
	output logic r3Full,
	output logic l1Empty,
	output logic l1Full,
	output bufferPkg::l0IdT l0IdLocal
);

	bufferPkg::sampleT heldSample;

	eventPortIf eventPort ();
	requestFifoIf r3Req ();
	requestFifoIf l1Req ();

	//****************************************
	// Capture path
	//****************************************
	pipelineBuffer pipelineBuffer_i (
		.CLK(CLK), .rstN(rstN), .l0a(l0a), .holdAddress(pipeHoldAddress),
		.data(data), .heldSample(heldSample)
	);

	eventBuffer eventBuffer_i (.CLK(CLK), .port(eventPort.mem));

	//****************************************
	// Request path
	//****************************************
	commandDetector #(.header(commandPkg::r3Header)) r3Detector_i (
		.CLK(CLK), .rstN(rstN), .serialIn(r3DataIn), .fifo(r3Req.writer)
	);
	commandDetector #(.header(commandPkg::l1Header)) l1Detector_i (
		.CLK(CLK), .rstN(rstN), .serialIn(l1DataIn), .fifo(l1Req.writer)
	);
	readoutFifo r3Fifo_i (.CLK(CLK), .rstN(rstN), .port(r3Req.fifo));
	readoutFifo l1Fifo_i (.CLK(CLK), .rstN(rstN), .port(l1Req.fifo));

	readoutControl readoutControl_i (
		.CLK(CLK), .rstN(rstN), .l0a(l0a), .l0IdReset(l0IdReset),
		.l0IdPreset(l0IdPreset), .preL0Id(preL0Id), .heldSample(heldSample),
		.r3ReadEnable(r3ReadEnable), .l1ReadEnable(l1ReadEnable),
		.r3Fifo(r3Req.reader), .l1Fifo(l1Req.reader), .mem(eventPort.ctrl),
		.l1bReadR3(l1bReadR3), .l1bReadL1(l1bReadL1), .l1bDataOut(l1bDataOut),
		.l0IdLocal(l0IdLocal)
	);

	// Queue flags out to the pins
	assign r3Empty = r3Req.empty;
	assign r3Full = r3Req.full;
	assign l1Empty = l1Req.empty;
	assign l1Full = l1Req.full;

endmodule

//--- testbench/l0l1BufferTb.sv
// Trigger buffer testbench
`timescale 1ns/1ps

module l0l1BufferTb;

	localparam int timeoutCycles = 20;

	logic CLK;
	logic rstN;
	logic l0a;
	logic l0IdReset;
	logic l0IdPreset;
	bufferPkg::l0IdT preL0Id;
	bufferPkg::pipeAddrT pipeHoldAddress;
	bufferPkg::sampleT data;
	logic r3DataIn;
	logic l1DataIn;
	logic r3ReadEnable;
	logic l1ReadEnable;
	logic l1bReadR3;
	logic l1bReadL1;
	bufferPkg::eventT l1bDataOut;
	logic r3Empty;
	logic r3Full;
	logic l1Empty;
	logic l1Full;
	bufferPkg::l0IdT l0IdLocal;

	int cycle;
	int errors;
	int testCount;
	int startErrors;
	int base;
	int latency;
	// Reference L0 counter
	bufferPkg::l0IdT modelId;
	bufferPkg::l0IdT pre;
	// Identifier and expected sample of every captured event
	bufferPkg::l0IdT capIds[$];
	bufferPkg::sampleT capSamples[$];

	l0l1Buffer l0l1Buffer_i (
		.CLK(CLK), .rstN(rstN), .l0a(l0a), .l0IdReset(l0IdReset),
		.l0IdPreset(l0IdPreset), .preL0Id(preL0Id), .pipeHoldAddress(pipeHoldAddress),
		.data(data), .r3DataIn(r3DataIn), .l1DataIn(l1DataIn),
		.r3ReadEnable(r3ReadEnable), .l1ReadEnable(l1ReadEnable),
		.l1bReadR3(l1bReadR3), .l1bReadL1(l1bReadL1), .l1bDataOut(l1bDataOut),
		.r3Empty(r3Empty), .r3Full(r3Full), .l1Empty(l1Empty), .l1Full(l1Full),
		.l0IdLocal(l0IdLocal)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	//****************************************
	// Stimulus helpers
	//****************************************
	// Advance one cycle and drive inputs 1 ns after the edge
	// Pipeline data is the cycle number itself
	task automatic tick();
		@(posedge CLK);
		#1;
		cycle++;
		data = bufferPkg::sampleT'(cycle);
	endtask

	// Consecutive L0 accepts at one random hold latency
	task automatic capture(input int count);
		bufferPkg::pipeAddrT hold;
		hold = bufferPkg::pipeAddrT'(1 + $urandom % 100);
		pipeHoldAddress = hold;
		for (int i = 0; i < count; i++) begin
			l0a = 1'b1;
			capIds.push_back(modelId);
			capSamples.push_back(bufferPkg::sampleT'(cycle - hold));
			modelId = modelId + 1'b1;
			tick();
		end
		l0a = 1'b0;
		// Event write lands one cycle after the last accept
		tick();
		tick();
	endtask

	// Header then identifier MSB first at one bit per cycle
	task automatic sendFrame(input logic toR3, input commandPkg::headerT head,
			input bufferPkg::l0IdT id);
		logic [commandPkg::headerBits+commandPkg::frameBits-1:0] bits;
		bits = {head, id};
		for (int i = $bits(bits) - 1; i >= 0; i--) begin
			if (toR3) r3DataIn = bits[i];
			else l1DataIn = bits[i];
			tick();
		end
		r3DataIn = 1'b0;
		l1DataIn = 1'b0;
		// Push happens now and the queue flags settle after it
		tick();
		tick();
	endtask

	task automatic pulseRead(input logic r3, input logic l1);
		r3ReadEnable = r3;
		l1ReadEnable = l1;
		tick();
		r3ReadEnable = 1'b0;
		l1ReadEnable = 1'b0;
	endtask

	// Cycles spent waiting beyond the current one
	task automatic waitStrobe(input logic wantR3, output int waited);
		waited = 0;
		while ((wantR3 ? l1bReadR3 : l1bReadL1) !== 1'b1 && waited < timeoutCycles) begin
			tick();
			waited++;
		end
		if ((wantR3 ? l1bReadR3 : l1bReadL1) !== 1'b1) begin
			$display("Timeout: no %s read strobe after %0d cycles at %0t ns",
				wantR3 ? "R3" : "L1", timeoutCycles, $time);
			errors++;
		end
	endtask

	//****************************************
	// Compare tasks
	//****************************************
	task automatic checkEvent(input bufferPkg::eventT got, input bufferPkg::eventT exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkL0Id(input bufferPkg::l0IdT got, input bufferPkg::l0IdT exp,
			input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// Read one queued event and compare it with the capture record
	task automatic readAndCheck(input logic fromR3, input int idx, input string what);
		int waited;
		pulseRead(fromR3, !fromR3);
		waitStrobe(fromR3, waited);
		checkFlag(logic'(waited == 0), 1'b1, {what, " strobe one cycle after enable"});
		checkEvent(l1bDataOut, {capIds[idx], capSamples[idx]}, what);
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errors == startErrors) $display("%s: passed", name);
		else $display("%s: %0d failed checks", name, errors - startErrors);
		startErrors = errors;
	endtask

	//****************************************
	// Directed tests
	//****************************************
	initial begin
		void'($urandom(32'h558d_db43));
		rstN = 1'b0;
		l0a = 1'b0;
		l0IdReset = 1'b0;
		l0IdPreset = 1'b0;
		preL0Id = '0;
		pipeHoldAddress = bufferPkg::pipeAddrT'(1);
		data = '0;
		r3DataIn = 1'b0;
		l1DataIn = 1'b0;
		r3ReadEnable = 1'b0;
		l1ReadEnable = 1'b0;
		cycle = 0;
		errors = 0;
		testCount = 0;
		startErrors = 0;
		modelId = '0;
		repeat (8) tick();
		rstN = 1'b1;
		// Fill the whole pipeline before any accept
		repeat (bufferPkg::pipeDepth + 2) tick();
		checkL0Id(l0IdLocal, '0, "identifier after reset");
		checkFlag(r3Empty, 1'b1, "R3 empty after reset");
		checkFlag(l1Empty, 1'b1, "L1 empty after reset");
		checkFlag(r3Full, 1'b0, "R3 full after reset");
		checkFlag(l1Full, 1'b0, "L1 full after reset");
		endTest("reset state");

		base = capIds.size();
		capture(1);
		checkL0Id(l0IdLocal, modelId, "identifier after one accept");
		sendFrame(1'b1, commandPkg::r3Header, capIds[base]);
		readAndCheck(1'b1, base, "R3 readout");
		endTest("capture and R3 readout");

		base = capIds.size();
		capture(4);
		checkL0Id(l0IdLocal, modelId, "identifier after four accepts");
		for (int k = 0; k < 4; k++) sendFrame(1'b0, commandPkg::l1Header, capIds[base+k]);
		for (int k = 0; k < 4; k++) readAndCheck(1'b0, base + k, "L1 readout of burst");
		endTest("back-to-back accepts");

		pre = bufferPkg::l0IdT'($urandom);
		preL0Id = pre;
		l0IdPreset = 1'b1;
		tick();
		l0IdPreset = 1'b0;
		modelId = pre;
		checkL0Id(l0IdLocal, pre, "identifier after preset");
		base = capIds.size();
		capture(1);
		sendFrame(1'b1, commandPkg::r3Header, pre);
		readAndCheck(1'b1, base, "event under preset identifier");
		// Reset must win over a simultaneous preset
		l0IdReset = 1'b1;
		l0IdPreset = 1'b1;
		tick();
		l0IdReset = 1'b0;
		l0IdPreset = 1'b0;
		modelId = '0;
		checkL0Id(l0IdLocal, '0, "identifier after reset");
		endTest("identifier reset and preset");

		base = capIds.size();
		capture(8);
		for (int k = 0; k < 8; k++) begin
			sendFrame(1'b1, commandPkg::r3Header, capIds[base+k]);
			sendFrame(1'b0, commandPkg::l1Header, capIds[base+k]);
			if (k == 6) begin
				checkFlag(r3Full, 1'b0, "R3 full after seven frames");
				checkFlag(l1Full, 1'b0, "L1 full after seven frames");
			end
		end
		checkFlag(r3Full, 1'b1, "R3 full after eight frames");
		checkFlag(l1Full, 1'b1, "L1 full after eight frames");
		// Ninth frame is dropped
		sendFrame(1'b1, commandPkg::r3Header, bufferPkg::l0IdT'($urandom));
		checkFlag(r3Full, 1'b1, "R3 full after ninth frame");
		for (int k = 0; k < 8; k++) readAndCheck(1'b1, base + k, "R3 queue order");
		for (int k = 0; k < 8; k++) readAndCheck(1'b0, base + k, "L1 queue order");
		checkFlag(r3Empty, 1'b1, "R3 empty after draining");
		checkFlag(l1Empty, 1'b1, "L1 empty after draining");
		checkFlag(l1Full, 1'b0, "L1 full after draining");
		pulseRead(1'b1, 1'b0);
		repeat (4) begin
			checkFlag(l1bReadR3, 1'b0, "no R3 strobe on empty queue");
			tick();
		end
		endTest("FIFO flags");

		base = capIds.size();
		capture(2);
		sendFrame(1'b1, commandPkg::r3Header, capIds[base]);
		sendFrame(1'b0, commandPkg::l1Header, capIds[base+1]);
		pulseRead(1'b1, 1'b1);
		waitStrobe(1'b1, latency);
		checkFlag(logic'(latency == 0), 1'b1, "R3 served first");
		checkFlag(l1bReadL1, 1'b0, "L1 held while R3 is served");
		checkEvent(l1bDataOut, {capIds[base], capSamples[base]}, "R3 event in arbitration");
		waitStrobe(1'b0, latency);
		checkFlag(logic'(latency == 1), 1'b1, "L1 served in the next cycle");
		checkEvent(l1bDataOut, {capIds[base+1], capSamples[base+1]}, "L1 event in arbitration");
		endTest("read arbitration");

		// Zero identifier keeps the payload from opening a new frame
		sendFrame(1'b1, 3'b111, '0);
		sendFrame(1'b0, 3'b111, '0);
		checkFlag(r3Empty, 1'b1, "R3 empty after bad header");
		checkFlag(l1Empty, 1'b1, "L1 empty after bad header");
		endTest("bad header");

		$display("Tests run: %0d, failed checks: %0d", testCount, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
source/bufferPkg.sv
source/commandPkg.sv
source/bufferIfs.sv
source/pipelineBuffer.sv
source/commandDetector.sv
source/readoutFifo.sv
source/eventBuffer.sv
source/readoutControl.sv
source/l0l1Buffer.sv
testbench/l0l1BufferTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the trigger buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module l0l1BufferTb -f build.f

out=$(./obj_dir/Vl0l1BufferTb) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TEST PASS'; then
	exit 0
fi
exit 1
